/* fc_pkg.sv */
`default_nettype none

package fc_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // engine sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int LANES      = 4;
    localparam int IN_LEN     = 64;
    localparam int OUT_LEN    = 16;
    localparam int PASSES     = OUT_LEN / LANES;
    localparam int WBUF_DEPTH = PASSES * IN_LEN;

    localparam int K_W     = $clog2(IN_LEN);     // input index width.
    localparam int PASS_W  = $clog2(PASSES);
    localparam int LANE_W  = $clog2(LANES);
    localparam int OUT_W   = $clog2(OUT_LEN);    // result buffer address width.
    localparam int WADDR_W = $clog2(WBUF_DEPTH); // per-lane weight address width.

    // region tag, byte address bits 21:19.
    typedef enum logic [2:0] {
        TAG_SA          = 3'd0,
        TAG_FC_WEIGHT   = 3'd1,
        TAG_FC_INPUT    = 3'd2,
        TAG_P_ADDR_BUF  = 3'd3,
        TAG_FC_DATA_BUF = 3'd4,
        TAG_SA_DATA_BUF = 3'd5,
        TAG_CTRL        = 3'd6
    } tag_e;

    typedef logic signed [7:0]  act_t;
    typedef logic signed [23:0] acc_t;

    typedef struct packed {
        logic sat;   // set when the value was clipped.
        act_t value;
    } fc_result_t;

    typedef struct packed {
        logic       start;
        logic [3:0] shift;
    } ctrl_t;

    typedef struct packed {
        logic busy;
        logic done;
    } status_t;

    typedef struct packed {
        logic               we;
        logic [WADDR_W-1:0] addr;
        act_t               data;
    } lane_wr_t;

    typedef struct packed {
        logic              valid;
        logic              first;
        logic              last;
        logic [K_W-1:0]    k;
        logic [PASS_W-1:0] pass;
    } step_t;

    typedef struct packed {
        logic valid;
        acc_t sum;
    } lane_res_t;

endpackage

`default_nettype wire

/* byte_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module byte_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 64
) (
    input  wire logic                     clk_a_i,
    input  wire logic                     we_i,
    input  wire logic [$clog2(DEPTH)-1:0] waddr_i,
    input  wire entry_t                   wdata_i,
    input  wire logic [$clog2(DEPTH)-1:0] raddr_i,
    output entry_t                        rdata_o
);

    entry_t mem [DEPTH];

    always_ff @(posedge clk_a_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        rdata_o <= mem[raddr_i]; // read data shows up one cycle after the address.
    end

endmodule

`default_nettype wire

/* addr_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module addr_decoder import fc_pkg::*; (
    input  wire logic             clk_a_i,
    input  wire logic             arst_n_i,
    input  wire logic [21:0]      addr_a_i,
    input  wire logic [31:0]      wrdata_a_i,
    input  wire logic             en_a_i,
    input  wire logic [3:0]       we_a_i,
    input  wire logic             busy_i,
    input  wire status_t          status_i,
    input  wire fc_result_t       res_rdata_i,
    output logic [31:0]           rddata_a_o,
    output lane_wr_t              lane_wr_o,
    output logic [LANES-1:0]      lane_sel_o,
    output logic                  in_we_o,
    output logic [K_W-1:0]        in_waddr_o,
    output act_t                  in_wdata_o,
    output logic [OUT_W-1:0]      res_raddr_o,
    output ctrl_t                 ctrl_o
);

    tag_e              tag;
    logic [14:0]       offset;
    logic              wr_stb;
    logic              rd_stb;
    logic [K_W-1:0]    w_k;
    logic [LANE_W-1:0] w_lane;
    logic [PASS_W-1:0] w_pass;
    logic              rd_valid_q;
    tag_e              rd_tag_q;

    assign tag    = tag_e'(addr_a_i[21:19]);
    assign offset = addr_a_i[16:2];
    assign wr_stb = en_a_i & we_a_i[0];
    assign rd_stb = en_a_i & ~we_a_i[0];

    // weight offset n*IN_LEN+k splits into k, lane n mod LANES and pass n/LANES.
    assign w_k    = offset[K_W-1:0];
    assign w_lane = offset[K_W +: LANE_W];
    assign w_pass = offset[K_W+LANE_W +: PASS_W];

    assign in_waddr_o  = offset[K_W-1:0];
    assign in_wdata_o  = act_t'(wrdata_a_i[7:0]);
    assign res_raddr_o = offset[OUT_W-1:0]; // result RAM is read on every access.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        lane_wr_o  = '0;
        lane_sel_o = '0;
        in_we_o    = 1'b0;
        ctrl_o     = '0;
        if (wr_stb) begin
            case (tag)
                TAG_FC_WEIGHT: begin
                    if (!busy_i) begin
                        lane_wr_o.we       = 1'b1;
                        lane_wr_o.addr     = {w_pass, w_k};
                        lane_wr_o.data     = act_t'(wrdata_a_i[7:0]);
                        lane_sel_o[w_lane] = 1'b1;
                    end
                end
                TAG_FC_INPUT: begin
                    in_we_o = ~busy_i; // the input vector is frozen during a run.
                end
                TAG_CTRL: begin
                    if (offset == '0) begin
                        ctrl_o.start = wrdata_a_i[0];
                        ctrl_o.shift = wrdata_a_i[4:1];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_a_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_q <= 1'b0;
            rd_tag_q   <= TAG_SA;
        end else begin
            rd_valid_q <= rd_stb;
            rd_tag_q   <= tag;
        end
    end

    // the RAM data and the tag of the read line up in the cycle after the strobe.
    always_comb begin
        rddata_a_o = '0;
        if (rd_valid_q) begin
            case (rd_tag_q)
                TAG_FC_DATA_BUF: begin
                    rddata_a_o = {15'b0, res_rdata_i.sat,
                                  {8{res_rdata_i.value[7]}}, res_rdata_i.value};
                end
                TAG_CTRL: begin
                    rddata_a_o = {30'b0, status_i};
                end
                default: begin
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* fc_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none

module fc_sequencer import fc_pkg::*; (
    input  wire logic  clk_a_i,
    input  wire logic  arst_n_i,
    input  wire ctrl_t ctrl_i,
    input  wire logic  last_write_i,
    output step_t      step_o,
    output logic [3:0] shift_o,
    output status_t    status_o
);

    status_t           status_q;
    logic              issue_q;
    logic [K_W-1:0]    k_q;
    logic [PASS_W-1:0] pass_q;
    logic [3:0]        shift_q;

    always_ff @(posedge clk_a_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            status_q <= '0;
            issue_q  <= 1'b0;
            k_q      <= '0;
            pass_q   <= '0;
            shift_q  <= '0;
        end else if (ctrl_i.start && !status_q.busy) begin
            status_q.busy <= 1'b1;
            status_q.done <= 1'b0;
            issue_q       <= 1'b1;
            k_q           <= '0;
            pass_q        <= '0;
            shift_q       <= ctrl_i.shift;
        end else begin
            if (issue_q) begin
                k_q <= k_q + 1'b1;
                if (k_q == K_W'(IN_LEN - 1)) begin
                    pass_q <= pass_q + 1'b1; // next pass follows with no gap.
                    if (pass_q == PASS_W'(PASSES - 1)) begin
                        issue_q <= 1'b0;
                    end
                end
            end
            // busy stays up until the collector has written the last result.
            if (last_write_i) begin
                status_q.busy <= 1'b0;
                status_q.done <= 1'b1;
            end
        end
    end

    always_comb begin
        step_o.valid = issue_q;
        step_o.first = issue_q && (k_q == '0);
        step_o.last  = issue_q && (k_q == K_W'(IN_LEN - 1));
        step_o.k     = k_q;
        step_o.pass  = pass_q;
    end

    assign shift_o  = shift_q;
    assign status_o = status_q;

endmodule

`default_nettype wire

/* fc_lane.sv */
`timescale 1ns/100ps
`default_nettype none

module fc_lane import fc_pkg::*; (
    input  wire logic     clk_a_i,
    input  wire logic     arst_n_i,
    input  wire lane_wr_t wr_i,
    input  wire logic     wr_sel_i,
    input  wire step_t    step_i,
    input  wire act_t     x_i,
    output lane_res_t     res_o
);

    act_t              w_rd;
    step_t             step_q;
    acc_t              acc_q;
    acc_t              acc_base;
    logic signed [15:0] prod;
    logic              res_valid_q;

    // weights of this lane, pass-major.
    byte_ram #(
        .entry_t (act_t),
        .DEPTH   (WBUF_DEPTH)
    ) wbuf_inst (
        .clk_a_i (clk_a_i),
        .we_i    (wr_i.we & wr_sel_i),
        .waddr_i (wr_i.addr),
        .wdata_i (wr_i.data),
        .raddr_i ({step_i.pass, step_i.k}),
        .rdata_o (w_rd)
    );

    // the step is delayed to match the one-cycle read of both RAMs.
    always_ff @(posedge clk_a_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            step_q      <= '0;
            res_valid_q <= 1'b0;
        end else begin
            step_q      <= step_i;
            res_valid_q <= step_q.valid & step_q.last;
        end
    end

    assign prod     = x_i * w_rd;
    assign acc_base = step_q.first ? acc_t'(0) : acc_q;

    always_ff @(posedge clk_a_i) begin
        if (step_q.valid) begin
            acc_q <= acc_base + acc_t'(prod);
        end
    end

    // the sum holds for one cycle before the next pass overwrites it.
    assign res_o.valid = res_valid_q;
    assign res_o.sum   = acc_q;

endmodule

`default_nettype wire

/* fc_collector.sv */
`timescale 1ns/100ps
`default_nettype none

module fc_collector import fc_pkg::*; (
    input  wire logic              clk_a_i,
    input  wire logic              arst_n_i,
    input  wire lane_res_t         res_i [LANES],
    input  wire logic [3:0]        shift_i,
    input  wire logic [PASS_W-1:0] pass_i,
    input  wire logic              final_pass_i,
    output logic                   we_o,
    output logic [OUT_W-1:0]       waddr_o,
    output fc_result_t             wdata_o,
    output logic                   last_write_o
);

    acc_t              sum_q [LANES];
    logic [PASS_W-1:0] pass_q;
    logic              final_q;
    logic              active_q;
    logic [LANE_W-1:0] idx_q;
    logic              res_valid;

    // arithmetic shift right, then clip to int8.
    function automatic fc_result_t requant(acc_t sum, logic [3:0] shift);
        acc_t       shifted;
        fc_result_t r;
        shifted = sum >>> shift;
        if (shifted > acc_t'(127)) begin
            r.sat   = 1'b1;
            r.value = 8'sh7f;
        end else if (shifted < acc_t'(-128)) begin
            r.sat   = 1'b1;
            r.value = 8'sh80;
        end else begin
            r.sat   = 1'b0;
            r.value = act_t'(shifted[7:0]);
        end
        return r;
    endfunction

    // all lanes run in lockstep so their valids coincide.
    always_comb begin
        res_valid = 1'b0;
        for (int i = 0; i < LANES; i++) begin
            res_valid = res_valid | res_i[i].valid;
        end
    end

    // by the time sums arrive the sequencer has moved on one pass.
    always_ff @(posedge clk_a_i) begin
        if (res_valid) begin
            for (int i = 0; i < LANES; i++) begin
                sum_q[i] <= res_i[i].sum;
            end
            pass_q <= pass_i - 1'b1;
        end
    end

    always_ff @(posedge clk_a_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            active_q <= 1'b0;
            idx_q    <= '0;
            final_q  <= 1'b0;
        end else if (res_valid) begin
            active_q <= 1'b1;
            idx_q    <= '0;
            final_q  <= final_pass_i;
        end else if (active_q) begin
            idx_q <= idx_q + 1'b1;
            if (idx_q == LANE_W'(LANES - 1)) begin
                active_q <= 1'b0;
            end
        end
    end

    assign we_o         = active_q;
    assign waddr_o      = {pass_q, idx_q}; // neuron pass*LANES + lane.
    assign wdata_o      = requant(sum_q[idx_q], shift_i);
    assign last_write_o = active_q & final_q & (idx_q == LANE_W'(LANES - 1));

endmodule

`default_nettype wire

/* fc_engine_top.sv */
`timescale 1ns/100ps
`default_nettype none

module fc_engine_top import fc_pkg::*; (
    input  wire logic        clk_a_i,
    input  wire logic        arst_n_i,
    input  wire logic [21:0] addr_a_i,
    input  wire logic [31:0] wrdata_a_i,
    input  wire logic        en_a_i,
    input  wire logic [3:0]  we_a_i,
    output logic [31:0]      rddata_a_o
);

    lane_wr_t         lane_wr;
    logic [LANES-1:0] lane_sel;
    logic             in_we;
    logic [K_W-1:0]   in_waddr;
    act_t             in_wdata;
    act_t             x_rd;
    logic [OUT_W-1:0] res_raddr;
    logic [OUT_W-1:0] res_waddr;
    fc_result_t       res_rdata;
    fc_result_t       res_wdata;
    logic             res_we;
    ctrl_t            ctrl;
    status_t          status;
    step_t            step;
    logic [3:0]       shift;
    logic             last_write;
    lane_res_t        lane_res [LANES];

    addr_decoder addr_decoder_inst (
        .clk_a_i     (clk_a_i),
        .arst_n_i    (arst_n_i),
        .addr_a_i    (addr_a_i),
        .wrdata_a_i  (wrdata_a_i),
        .en_a_i      (en_a_i),
        .we_a_i      (we_a_i),
        .busy_i      (status.busy),
        .status_i    (status),
        .res_rdata_i (res_rdata),
        .rddata_a_o  (rddata_a_o),
        .lane_wr_o   (lane_wr),
        .lane_sel_o  (lane_sel),
        .in_we_o     (in_we),
        .in_waddr_o  (in_waddr),
        .in_wdata_o  (in_wdata),
        .res_raddr_o (res_raddr),
        .ctrl_o      (ctrl)
    );

    byte_ram #(.entry_t(act_t), .DEPTH(IN_LEN)) in_ram_inst (
        .clk_a_i (clk_a_i),
        .we_i    (in_we),
        .waddr_i (in_waddr),
        .wdata_i (in_wdata),
        .raddr_i (step.k),
        .rdata_o (x_rd)
    );

    byte_ram #(.entry_t(fc_result_t), .DEPTH(OUT_LEN)) res_ram_inst (
        .clk_a_i (clk_a_i),
        .we_i    (res_we),
        .waddr_i (res_waddr),
        .wdata_i (res_wdata),
        .raddr_i (res_raddr),
        .rdata_o (res_rdata)
    );

    fc_sequencer fc_sequencer_inst (
        .clk_a_i      (clk_a_i),
        .arst_n_i     (arst_n_i),
        .ctrl_i       (ctrl),
        .last_write_i (last_write),
        .step_o       (step),
        .shift_o      (shift),
        .status_o     (status)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // MAC lanes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    for (genvar g = 0; g < LANES; g++) begin : g_lane
        fc_lane fc_lane_inst (
            .clk_a_i  (clk_a_i),
            .arst_n_i (arst_n_i),
            .wr_i     (lane_wr),
            .wr_sel_i (lane_sel[g]),
            .step_i   (step),
            .x_i      (x_rd), // one input value is shared by all lanes.
            .res_o    (lane_res[g])
        );
    end

    // no step is issued any more once the final pass has drained.
    fc_collector fc_collector_inst (
        .clk_a_i      (clk_a_i),
        .arst_n_i     (arst_n_i),
        .res_i        (lane_res),
        .shift_i      (shift),
        .pass_i       (step.pass),
        .final_pass_i (~step.valid),
        .we_o         (res_we),
        .waddr_o      (res_waddr),
        .wdata_o      (res_wdata),
        .last_write_o (last_write)
    );

endmodule

`default_nettype wire

/* tb_fc_engine.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_fc_engine import fc_pkg::*; ();

    localparam int SEED        = 13;
    localparam int RUNS        = 7;     // engine runs over all tests.
    localparam int HOST_CYCLES = 2400;  // loading one full data set plus readback.
    localparam int WATCHDOG    = RUNS * (PASSES * IN_LEN + 64 + HOST_CYCLES) + 2000;
    localparam int MAX_POLLS   = 400;

    logic        clk_a;
    logic        arst_n;
    logic [21:0] addr_a;
    logic [31:0] wrdata_a;
    logic        en_a;
    logic [3:0]  we_a;
    logic [31:0] rddata_a;

    logic [15:0] lfsr_q;
    act_t        w_m [OUT_LEN][IN_LEN];
    act_t        x_m [IN_LEN];
    int          cur_shift;
    int          errors;
    int          checks;

    fc_engine_top fc_engine_top_inst (
        .clk_a_i    (clk_a),
        .arst_n_i   (arst_n),
        .addr_a_i   (addr_a),
        .wrdata_a_i (wrdata_a),
        .en_a_i     (en_a),
        .we_a_i     (we_a),
        .rddata_a_o (rddata_a)
    );

    initial begin
        clk_a = 1'b0;
        forever #20 clk_a = ~clk_a;
    end

    initial begin
        repeat (WATCHDOG) @(posedge clk_a);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG);
        $display("FAIL: see errors above");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random source and reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic fc_result_t expect_result(int n, int shift);
        int         sum;
        int         sh;
        fc_result_t r;
        sum = 0;
        for (int k = 0; k < IN_LEN; k++) begin
            sum += int'(x_m[k]) * int'(w_m[n][k]);
        end
        sh = sum >>> shift;
        r.sat = (sh > 127) || (sh < -128);
        r.value = (sh > 127) ? 8'sh7f : (sh < -128) ? 8'sh80 : act_t'(sh);
        return r;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_result(fc_result_t got, fc_result_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got sat %b value %0d, expected sat %b value %0d",
                     $time, what, got.sat, got.value, exp.sat, exp.value);
        end
    endtask

    task automatic check_status(status_t got, status_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got busy %b done %b, expected busy %b done %b",
                     $time, what, got.busy, got.done, exp.busy, exp.done);
        end
    endtask

    task automatic check_word(logic [31:0] got, logic [31:0] exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host port A accesses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic host_write(tag_e tag, int offset, logic [31:0] data);
        @(negedge clk_a);
        addr_a   = {tag, 2'b00, 15'(offset), 2'b00};
        wrdata_a = data;
        en_a     = 1'b1;
        we_a     = 4'b0001;
        @(negedge clk_a);
        en_a = 1'b0;
        we_a = 4'b0000;
    endtask

    task automatic host_read(tag_e tag, int offset, output logic [31:0] data);
        @(negedge clk_a);
        addr_a = {tag, 2'b00, 15'(offset), 2'b00};
        en_a   = 1'b1;
        we_a   = 4'b0000;
        @(negedge clk_a);
        data = rddata_a; // read data belongs to the cycle after the strobe.
        en_a = 1'b0;
    endtask

    task automatic set_weight(int n, int k, act_t v);
        w_m[n][k] = v;
        host_write(TAG_FC_WEIGHT, n * IN_LEN + k, {24'b0, v});
    endtask

    task automatic load_random_data();
        act_t v;
        for (int n = 0; n < OUT_LEN; n++) begin
            for (int k = 0; k < IN_LEN; k++) begin
                v = act_t'(rand_bits(8));
                set_weight(n, k, v);
            end
        end
        for (int k = 0; k < IN_LEN; k++) begin
            x_m[k] = act_t'(rand_bits(8));
            host_write(TAG_FC_INPUT, k, {24'b0, x_m[k]});
        end
    endtask

    task automatic start_run(int shift);
        cur_shift = shift;
        host_write(TAG_CTRL, 0, {27'b0, 4'(shift), 1'b1});
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        status_t     st;
        int          polls;
        st    = '0;
        polls = 0;
        while (!st.done && polls < MAX_POLLS) begin
            host_read(TAG_CTRL, 0, rd);
            st = status_t'(rd[1:0]);
            polls++;
        end
        if (!st.done) begin
            errors++;
            $display("the engine never reported done within %0d status polls", polls);
        end else begin
            check_status(st, status_t'{busy: 1'b0, done: 1'b1}, "status after run");
        end
    endtask

    task automatic read_result(int n, fc_result_t exp);
        logic [31:0] rd;
        fc_result_t  got;
        host_read(TAG_FC_DATA_BUF, n, rd);
        got.sat   = rd[16];
        got.value = act_t'(rd[7:0]);
        check_result(got, exp, $sformatf("result %0d", n));
        if (rd[31:17] !== '0 || rd[15:8] !== {8{rd[7]}}) begin
            errors++;
            $display("Error at %0t: result %0d word %h is not sign-extended", $time, n, rd);
        end
    endtask

    task automatic check_all_results();
        for (int n = 0; n < OUT_LEN; n++) begin
            read_result(n, expect_result(n, cur_shift));
        end
    endtask

    task automatic report_test(int num, string name, int errors_before);
        $display("test %0d %s: %0d errors", num, name, errors - errors_before);
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        logic [31:0] rd;
        int          e0;
        int          dropped;
        tag_e        rsv [3];
        addr_a    = '0;
        wrdata_a  = '0;
        en_a      = 1'b0;
        we_a      = 4'b0000;
        arst_n    = 1'b0;
        lfsr_q    = 16'(SEED);
        cur_shift = 0;
        errors    = 0;
        checks    = 0;
        rsv       = '{TAG_SA, TAG_P_ADDR_BUF, TAG_SA_DATA_BUF};
        repeat (3) @(negedge clk_a);
        arst_n = 1'b1;

        e0 = errors;
        check_word(rddata_a, '0, "read data with no read pending");
        host_read(TAG_CTRL, 0, rd);
        check_status(status_t'(rd[1:0]), status_t'{busy: 1'b0, done: 1'b0}, "status after reset");
        check_word(rd, '0, "status word after reset");
        for (int n = 0; n < OUT_LEN; n++) begin
            read_result(n, '0);
        end
        report_test(1, "reset state", e0);

        e0 = errors;
        load_random_data();
        start_run(0);
        wait_done();
        check_all_results();
        report_test(2, "random data, shift 0", e0);

        // sign-matched weights drive neurons 0 and 1 far into both rails.
        e0 = errors;
        for (int r = 0; r < 4; r++) begin
            load_random_data();
            for (int k = 0; k < IN_LEN; k++) begin
                set_weight(0, k, (x_m[k] >= 0) ? 8'sh7f : 8'sh80);
                set_weight(1, k, (x_m[k] >= 0) ? 8'sh80 : 8'sh7f);
            end
            start_run((r == 0) ? int'(rand_bits(3)) : int'(rand_bits(4)));
            wait_done();
            check_all_results();
        end
        report_test(3, "random shifts", e0);

        e0 = errors;
        load_random_data();
        start_run(int'(rand_bits(4)));
        dropped = 0;
        for (int i = 0; i < 16; i++) begin
            host_read(TAG_CTRL, 0, rd);
            if (rd[1]) begin // the model keeps the old data.
                host_write(TAG_FC_WEIGHT, int'(rand_bits(10)), rand_bits(8));
                host_write(TAG_FC_INPUT, int'(rand_bits(6)), rand_bits(8));
                dropped++;
            end
        end
        if (dropped == 0) begin
            errors++;
            $display("the engine never reported busy after a start");
        end
        wait_done();
        check_all_results();
        report_test(4, "writes while busy", e0);

        e0 = errors;
        for (int t = 0; t < 3; t++) begin
            for (int i = 0; i < 8; i++) begin
                host_write(rsv[t], int'(rand_bits(15)), rand_bits(32));
            end
            host_read(rsv[t], int'(rand_bits(15)), rd);
            check_word(rd, '0, $sformatf("read of reserved tag %0d", rsv[t]));
        end
        check_all_results();
        start_run(cur_shift);
        wait_done();
        check_all_results();
        report_test(5, "reserved tags", e0);

        $display("tests: 5, checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
fc_pkg.sv
byte_ram.sv
addr_decoder.sv
fc_sequencer.sv
fc_lane.sv
fc_collector.sv
fc_engine_top.sv
tb_fc_engine.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_fc_engine
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/100ps
PASS_TEXT ?= PASS: all tests

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
